// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mvu_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := mvu_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+.
mvu_pkg.sv
mvu_bitstep_if.sv
mvu_apb_regs.sv
mvu_plane_mem.sv
mvu_agu.sv
mvu_vvp.sv
mvu_top.sv
tb_mvu_top.sv

// File: mvu_agu.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvu_params.svh"

module mvu_agu (
    input  logic                    intf,
    input  logic                    reset,
    input  logic                    start,
    input  mvu_pkg::mvu_config_u    cfg,
    mvu_bitstep_if.source           step
);

    import mvu_pkg::*;

    mvu_config_u            cfg_q;          // Job parameters held for the run
    logic                   run;
    logic [`MVU_PREC_W-1:0] wbit;
    logic [`MVU_PREC_W-1:0] ibit;
    logic                   w_msb;
    logic                   i_msb;

    // Input bit steps every cycle, weight bit on input wrap
    always_ff @(posedge intf) begin
        if (reset) begin
            run  <= 1'b0;
            wbit <= '0;
            ibit <= '0;
        end else if (start) begin
            run  <= 1'b1;
            wbit <= cfg.f.wprec_m1;         // Both start at MSB
            ibit <= cfg.f.iprec_m1;
        end else if (run) begin
            if (ibit == '0) begin
                ibit <= cfg_q.f.iprec_m1;
                if (wbit == '0) begin
                    run <= 1'b0;            // All pairs issued
                end else begin
                    wbit <= wbit - 1'b1;
                end
            end else begin
                ibit <= ibit - 1'b1;
            end
        end
    end

    always_ff @(posedge intf) begin
        if (start) begin
            cfg_q <= cfg;
        end
    end

    assign w_msb = (wbit == cfg_q.f.wprec_m1);
    assign i_msb = (ibit == cfg_q.f.iprec_m1);

    assign step.valid = run;
    assign step.waddr = cfg_q.f.wbase + `MVU_ADDR_W'(wbit);
    assign step.iaddr = cfg_q.f.ibase + `MVU_ADDR_W'(ibit);
    assign step.shift = `MVU_SHIFT_W'(wbit) + `MVU_SHIFT_W'(ibit);

    // A signed MSB carries negative weight; two of them cancel
    assign step.negate = (cfg_q.f.w_signed & w_msb) ^ (cfg_q.f.i_signed & i_msb);
    assign step.last   = (wbit == '0) && (ibit == '0);

endmodule

`default_nettype wire

// File: mvu_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvu_params.svh"

module mvu_apb_regs (
    input  logic                    intf,
    input  logic                    reset,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`APB_DATA_W-1:0]  pwdata,
    output logic [`APB_DATA_W-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    output mvu_pkg::mvu_config_u    cfg,
    output logic                    start,
    output logic                    dmem_wr_en,
    output logic                    wmem_wr_en,
    output logic [`MVU_ADDR_W-1:0]  mem_wr_addr,
    output logic [`MVU_N-1:0]       mem_wr_data,
    input  logic                    done,
    input  logic [`MVU_ACC_W-1:0]   result,
    output logic                    irq
);

    localparam logic [`APB_ADDR_W-1:0] WIN_MASK = `APB_ADDR_W'(`MVU_MEM_SPAN - 1);

    logic                   access;
    logic                   wr;
    logic                   is_cfg;
    logic                   is_ctrl;
    logic                   is_status;
    logic                   is_result;
    logic                   is_dmem;
    logic                   is_wmem;
    logic                   mapped;
    logic                   start_req;
    logic                   mem_req;
    logic                   busy;
    logic                   done_flag;      // Sticky until next start
    logic [`MVU_ACC_W-1:0]  result_q;

    assign access = psel & penable;         // Access phase, always zero wait
    assign wr     = access & pwrite;

    assign is_cfg    = (paddr == `MVU_REG_CONFIG);
    assign is_ctrl   = (paddr == `MVU_REG_CONTROL);
    assign is_status = (paddr == `MVU_REG_STATUS);
    assign is_result = (paddr == `MVU_REG_RESULT);
    assign is_dmem   = ((paddr & ~WIN_MASK) == `MVU_DMEM_BASE) && (paddr[1:0] == 2'b00);
    assign is_wmem   = ((paddr & ~WIN_MASK) == `MVU_WMEM_BASE) && (paddr[1:0] == 2'b00);
    assign mapped    = is_cfg | is_ctrl | is_status | is_result | is_dmem | is_wmem;

    assign start_req = wr & is_ctrl & pwdata[0];
    assign mem_req   = wr & (is_dmem | is_wmem);

    // Refused starts and memory writes while a job runs
    assign pready  = 1'b1;
    assign pslverr = access & (~mapped | (busy & (start_req | mem_req)));

    assign start       = start_req & ~busy;
    assign dmem_wr_en  = wr & is_dmem & ~busy;
    assign wmem_wr_en  = wr & is_wmem & ~busy;
    assign mem_wr_addr = paddr[`MVU_ADDR_W+1:2];    // Byte to word address
    assign mem_wr_data = pwdata[`MVU_N-1:0];

    assign irq = done_flag;

    always_ff @(posedge intf) begin
        if (reset) begin
            cfg       <= '0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            result_q  <= '0;
        end else begin
            if (wr && is_cfg) begin
                cfg.raw <= pwdata;
            end
            if (start) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
                result_q  <= result;                // Signed sum of the job
            end
        end
    end

    always_comb begin
        case (paddr)
            `MVU_REG_CONFIG: prdata = cfg.raw;
            `MVU_REG_STATUS: prdata = {{(`APB_DATA_W-2){1'b0}}, done_flag, busy};
            `MVU_REG_RESULT: prdata = `APB_DATA_W'(result_q);
            default:         prdata = '0;           // Control and memories read zero
        endcase
    end

endmodule

`default_nettype wire

// File: mvu_bitstep_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvu_params.svh"

// One weight/input plane pair per cycle, no back-pressure
interface mvu_bitstep_if ();

    logic                    valid;
    logic [`MVU_ADDR_W-1:0]  waddr;     // Weight plane address
    logic [`MVU_ADDR_W-1:0]  iaddr;     // Input plane address
    logic [`MVU_SHIFT_W-1:0] shift;     // Combined bit significance
    logic                    negate;    // Subtract this partial
    logic                    last;      // Final pair of the job

    modport source (
        output valid, waddr, iaddr, shift, negate, last
    );

    modport sink (
        input valid, waddr, iaddr, shift, negate, last
    );

endinterface

`default_nettype wire

// File: mvu_params.svh
`ifndef MVU_PARAMS_SVH
`define MVU_PARAMS_SVH

// Vector and plane memory geometry
`define MVU_N           16          // Elements per vector, bits per plane word
`define MVU_ADDR_W      6           // Plane memory address width
`define MVU_MEM_DEPTH   64
`define MVU_PREC_W      3           // Precision fields hold precision minus one
`define MVU_SHIFT_W     4           // Weight bit plus input bit
`define MVU_ACC_W       32          // Accumulator and result

// APB slave widths
`define APB_ADDR_W      12
`define APB_DATA_W      32

// Register map, byte offsets
`define MVU_REG_CONFIG  12'h000
`define MVU_REG_CONTROL 12'h004     // Bit 0 starts a job
`define MVU_REG_STATUS  12'h008     // Bit 0 busy, bit 1 done
`define MVU_REG_RESULT  12'h00C

// Plane memory windows, word address times 4
`define MVU_DMEM_BASE   12'h100
`define MVU_WMEM_BASE   12'h200
`define MVU_MEM_SPAN    12'h100     // Bytes covered by one window

`endif

// File: mvu_pkg.sv
`default_nettype none

`include "mvu_params.svh"

package mvu_pkg;

    // Bits left over above the used config fields
    localparam int CFG_RSV_W = `APB_DATA_W - 2 * `MVU_PREC_W - 2 - 2 * `MVU_ADDR_W;

    // Field view of the CONFIG word, last member sits at bit 0
    typedef struct packed {
        logic [CFG_RSV_W-1:0]   reserved;   // Bits 31:20
        logic [`MVU_ADDR_W-1:0] ibase;      // Bits 19:14, data memory base
        logic [`MVU_ADDR_W-1:0] wbase;      // Bits 13:8, weight memory base
        logic                   i_signed;   // Bit 7
        logic                   w_signed;   // Bit 6
        logic [`MVU_PREC_W-1:0] iprec_m1;   // Bits 5:3
        logic [`MVU_PREC_W-1:0] wprec_m1;   // Bits 2:0
    } mvu_config_fields_t;

    // Same word seen by APB as raw data and by the lane as fields
    typedef union packed {
        logic [`APB_DATA_W-1:0] raw;
        mvu_config_fields_t     f;
    } mvu_config_u;

endpackage

`default_nettype wire

// File: mvu_plane_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvu_params.svh"

// One bit of every element per word
module mvu_plane_mem (
    input  logic                    intf,
    input  logic                    wr_en,
    input  logic [`MVU_ADDR_W-1:0]  wr_addr,
    input  logic [`MVU_N-1:0]       wr_data,
    input  logic [`MVU_ADDR_W-1:0]  rd_addr,
    output logic [`MVU_N-1:0]       rd_data
);

    logic [`MVU_N-1:0] mem [0:`MVU_MEM_DEPTH-1];

    always_ff @(posedge intf) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read every cycle, data one cycle behind the address
    always_ff @(posedge intf) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: mvu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvu_params.svh"

module mvu_top (
    input  logic                    intf,
    input  logic                    reset,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`APB_DATA_W-1:0]  pwdata,
    output logic [`APB_DATA_W-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    irq
);

    import mvu_pkg::*;

    mvu_config_u            cfg;
    logic                   start;
    logic                   dmem_wr_en;
    logic                   wmem_wr_en;
    logic [`MVU_ADDR_W-1:0] mem_wr_addr;
    logic [`MVU_N-1:0]      mem_wr_data;
    logic                   done;
    logic [`MVU_ACC_W-1:0]  result;
    logic [`MVU_N-1:0]      dplane;
    logic [`MVU_N-1:0]      wplane;

    mvu_bitstep_if step ();

    mvu_apb_regs u_regs (
        .intf        (intf),
        .reset       (reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .cfg         (cfg),
        .start       (start),
        .dmem_wr_en  (dmem_wr_en),
        .wmem_wr_en  (wmem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .done        (done),
        .result      (result),
        .irq         (irq)
    );

    // Input planes
    mvu_plane_mem u_dmem (
        .intf    (intf),
        .wr_en   (dmem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_addr (step.iaddr),
        .rd_data (dplane)
    );

    // Weight planes
    mvu_plane_mem u_wmem (
        .intf    (intf),
        .wr_en   (wmem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_addr (step.waddr),
        .rd_data (wplane)
    );

    mvu_agu u_agu (
        .intf  (intf),
        .reset (reset),
        .start (start),
        .cfg   (cfg),
        .step  (step.source)
    );

    mvu_vvp u_vvp (
        .intf   (intf),
        .reset  (reset),
        .start  (start),
        .step   (step.sink),
        .dplane (dplane),
        .wplane (wplane),
        .done   (done),
        .result (result)
    );

endmodule

`default_nettype wire

// File: mvu_vvp.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvu_params.svh"

module mvu_vvp (
    input  logic                    intf,
    input  logic                    reset,
    input  logic                    start,
    mvu_bitstep_if.sink             step,
    input  logic [`MVU_N-1:0]       dplane,
    input  logic [`MVU_N-1:0]       wplane,
    output logic                    done,
    output logic [`MVU_ACC_W-1:0]   result
);

    localparam int POP_W = $clog2(`MVU_N + 1);

    logic                    valid_d;       // Step aligned with memory data
    logic [`MVU_SHIFT_W-1:0] shift_d;
    logic                    negate_d;
    logic                    last_d;
    logic [`MVU_N-1:0]       match;
    logic [POP_W-1:0]        pop;
    logic [`MVU_ACC_W-1:0]   magnitude;
    logic [`MVU_ACC_W-1:0]   partial;
    logic                    part_valid;
    logic                    part_last;
    logic [`MVU_ACC_W-1:0]   acc;
    logic                    done_q;

    assign match = dplane & wplane;

    always_comb begin
        pop = '0;
        for (int b = 0; b < `MVU_N; b++) begin
            pop = pop + POP_W'(match[b]);
        end
    end

    assign magnitude = `MVU_ACC_W'(pop) << shift_d;

    always_ff @(posedge intf) begin
        if (reset) begin
            valid_d    <= 1'b0;
            part_valid <= 1'b0;
            part_last  <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            valid_d    <= step.valid;
            part_valid <= valid_d;
            part_last  <= valid_d & last_d;
            done_q     <= part_last;        // Final sum lands with this pulse
        end
    end

    always_ff @(posedge intf) begin
        shift_d  <= step.shift;             // Memory read latency
        negate_d <= step.negate;
        last_d   <= step.last;
        partial  <= negate_d ? -magnitude : magnitude;
    end

    always_ff @(posedge intf) begin
        if (start) begin
            acc <= '0;
        end else if (part_valid) begin
            acc <= acc + partial;
        end
    end

    assign done   = done_q;
    assign result = acc;

endmodule

`default_nettype wire

// File: tb_mvu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvu_params.svh"

module tb_mvu_top;

    localparam int CYCLE_LIMIT     = 20000;  // About 12 jobs of at most 200 cycles, ample margin
    localparam int IRQ_WAIT_LIMIT  = 100;    // Longest job is 8x8 pairs plus 3

    logic                   intf;
    logic                   reset;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   irq;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int wv [0:`MVU_N-1];                     // Weight element values
    int iv [0:`MVU_N-1];                     // Input element values

    mvu_top u_dut (
        .intf    (intf),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    initial begin
        intf = 1'b0;
        forever #2 intf = ~intf;
    end

    always @(posedge intf) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    // Entered and left on a falling edge
    task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr,
                             input logic [`APB_DATA_W-1:0] data, output logic err);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge intf);
        penable = 1'b1;                      // Access cycle
        #1;
        err = pslverr;
        check_equal(32'(pready), 32'd1, "pready");
        @(negedge intf);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr,
                            output logic [`APB_DATA_W-1:0] data, output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge intf);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge intf);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [`APB_DATA_W-1:0] make_config(input int wprec, input int iprec,
            input bit w_sgn, input bit i_sgn, input int wbase, input int ibase);
        logic [`APB_DATA_W-1:0] c;
        c        = '0;
        c[2:0]   = 3'(wprec - 1);
        c[5:3]   = 3'(iprec - 1);
        c[6]     = w_sgn;
        c[7]     = i_sgn;
        c[13:8]  = 6'(wbase);
        c[19:14] = 6'(ibase);
        return c;
    endfunction

    function automatic int random_element(input int prec, input bit sgn);
        int r;
        r = int'($urandom % (32'd1 << prec));
        if (sgn) begin
            r = r - (1 << (prec - 1));       // Shift into two's complement range
        end
        return r;
    endfunction

    function automatic int model_dot();
        int s;
        s = 0;
        for (int e = 0; e < `MVU_N; e++) begin
            s = s + wv[e] * iv[e];
        end
        return s;
    endfunction

    task automatic fill_random(input int wprec, input int iprec, input bit w_sgn,
                               input bit i_sgn);
        for (int e = 0; e < `MVU_N; e++) begin
            wv[e] = random_element(wprec, w_sgn);
            iv[e] = random_element(iprec, i_sgn);
        end
    endtask

    // Plane b holds bit b of every element, element e at bit e
    task automatic load_vectors(input int wprec, input int iprec, input int wbase,
                                input int ibase);
        logic [`MVU_N-1:0] plane;
        logic              err;
        for (int b = 0; b < wprec; b++) begin
            for (int e = 0; e < `MVU_N; e++) plane[e] = wv[e][b];
            apb_write(`MVU_WMEM_BASE + 12'((wbase + b) * 4), 32'(plane), err);
            check_equal(32'(err), 32'd0, "pslverr on weight plane write");
        end
        for (int b = 0; b < iprec; b++) begin
            for (int e = 0; e < `MVU_N; e++) plane[e] = iv[e][b];
            apb_write(`MVU_DMEM_BASE + 12'((ibase + b) * 4), 32'(plane), err);
            check_equal(32'(err), 32'd0, "pslverr on input plane write");
        end
    endtask

    task automatic start_job();
        logic err;
        apb_write(`MVU_REG_CONTROL, 32'd1, err);
        check_equal(32'(err), 32'd0, "pslverr on idle start");
    endtask

    // Counts cycles from the start access edge
    task automatic wait_for_irq(output int n);
        n = 0;
        while (irq !== 1'b1 && n < IRQ_WAIT_LIMIT) begin
            @(negedge intf);
            n++;
        end
        if (irq !== 1'b1) begin
            errors++;
            $display("irq did not rise within %0d cycles of the start", IRQ_WAIT_LIMIT);
        end
    endtask

    task automatic run_job(input logic [`APB_DATA_W-1:0] cfg_word,
                           output logic [`APB_DATA_W-1:0] res, output int latency);
        logic err;
        apb_write(`MVU_REG_CONFIG, cfg_word, err);
        check_equal(32'(err), 32'd0, "pslverr on CONFIG write");
        start_job();
        wait_for_irq(latency);
        apb_read(`MVU_REG_RESULT, res, err);
    endtask

    task automatic check_job(input int wprec, input int iprec, input bit w_sgn,
            input bit i_sgn, input int wbase, input int ibase, input string name);
        logic [`APB_DATA_W-1:0] res;
        int                     latency;
        load_vectors(wprec, iprec, wbase, ibase);
        run_job(make_config(wprec, iprec, w_sgn, i_sgn, wbase, ibase), res, latency);
        check_equal(res, 32'(model_dot()), {name, " RESULT"});
        check_equal(32'(latency), 32'(wprec * iprec + 3), {name, " start to irq cycles"});
    endtask

    task automatic reset_state_check();
        logic [`APB_DATA_W-1:0] data;
        logic                   err;
        check_equal(32'(irq), 32'd0, "irq after reset");
        apb_read(`MVU_REG_STATUS, data, err);
        check_equal(data, 32'd0, "STATUS after reset");
        apb_read(`MVU_REG_RESULT, data, err);
        check_equal(data, 32'd0, "RESULT after reset");
        apb_read(`MVU_REG_CONFIG, data, err);
        check_equal(data, 32'd0, "CONFIG after reset");
        apb_write(`MVU_REG_CONFIG, 32'hA5C3_5A7E, err);
        apb_read(`MVU_REG_CONFIG, data, err);
        check_equal(data, 32'hA5C3_5A7E, "CONFIG readback");
    endtask

    task automatic unsigned_random_jobs();
        for (int j = 0; j < 3; j++) begin
            fill_random(4, 4, 1'b0, 1'b0);
            check_job(4, 4, 1'b0, 1'b0, 0, 0, "unsigned 4x4");
        end
    endtask

    task automatic signed_precision_jobs();
        fill_random(1, 1, 1'b1, 1'b1);
        check_job(1, 1, 1'b1, 1'b1, 0, 0, "signed 1x1");
        fill_random(3, 3, 1'b1, 1'b1);
        check_job(3, 3, 1'b1, 1'b1, 4, 4, "signed 3x3");
        fill_random(8, 8, 1'b1, 1'b1);
        check_job(8, 8, 1'b1, 1'b1, 16, 16, "signed 8x8");
        for (int e = 0; e < `MVU_N; e++) begin
            wv[e] = -128;                    // Every element at its minimum
            iv[e] = -128;
        end
        check_job(8, 8, 1'b1, 1'b1, 24, 24, "signed 8x8 minimum");
    endtask

    task automatic mixed_sign_jobs();
        fill_random(5, 3, 1'b1, 1'b0);
        check_job(5, 3, 1'b1, 1'b0, 10, 40, "weights signed, inputs unsigned");
        fill_random(2, 6, 1'b0, 1'b1);
        check_job(2, 6, 1'b0, 1'b1, 33, 7, "weights unsigned, inputs signed");
    endtask

    task automatic start_timing_check();
        logic [`APB_DATA_W-1:0] data;
        logic                   err;
        int                     n;
        fill_random(4, 4, 1'b0, 1'b0);
        check_job(4, 4, 1'b0, 1'b0, 50, 50, "timing 4x4");
        apb_read(`MVU_REG_STATUS, data, err);
        check_equal(data, 32'h2, "STATUS after job");      // Done set, busy clear
        start_job();
        check_equal(32'(irq), 32'd0, "irq after restart");
        apb_read(`MVU_REG_STATUS, data, err);
        check_equal(data, 32'h1, "STATUS while running");
        wait_for_irq(n);
        apb_read(`MVU_REG_RESULT, data, err);
        check_equal(data, 32'(model_dot()), "restarted job RESULT");
    endtask

    task automatic busy_error_check();
        logic [`APB_DATA_W-1:0] data;
        logic [`MVU_N-1:0]      plane;
        logic                   err;
        int                     n;
        fill_random(8, 8, 1'b1, 1'b1);
        load_vectors(8, 8, 30, 40);
        apb_write(`MVU_REG_CONFIG, make_config(8, 8, 1'b1, 1'b1, 30, 40), err);
        start_job();
        apb_write(`MVU_REG_CONTROL, 32'd1, err);
        check_equal(32'(err), 32'd1, "pslverr on start while busy");
        for (int e = 0; e < `MVU_N; e++) plane[e] = ~iv[e][0];
        apb_write(`MVU_DMEM_BASE + 12'(40 * 4), 32'(plane), err);   // Would corrupt plane 0
        check_equal(32'(err), 32'd1, "pslverr on input write while busy");
        for (int e = 0; e < `MVU_N; e++) plane[e] = ~wv[e][7];
        apb_write(`MVU_WMEM_BASE + 12'(37 * 4), 32'(plane), err);
        check_equal(32'(err), 32'd1, "pslverr on weight write while busy");
        apb_write(12'h010, 32'hFFFF_FFFF, err);
        check_equal(32'(err), 32'd1, "pslverr on unmapped write");
        apb_read(12'h3F0, data, err);
        check_equal(32'(err), 32'd1, "pslverr on unmapped read");
        wait_for_irq(n);
        apb_read(`MVU_REG_RESULT, data, err);
        check_equal(data, 32'(model_dot()), "RESULT after refused transfers");
        apb_read(`MVU_REG_CONFIG, data, err);
        check_equal(data, make_config(8, 8, 1'b1, 1'b1, 30, 40), "CONFIG after refusals");
    endtask

    initial begin
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(84));
        repeat (3) @(posedge intf);
        @(negedge intf);
        reset = 1'b0;
        reset_state_check();
        unsigned_random_jobs();
        signed_precision_jobs();
        mixed_sign_jobs();
        start_timing_check();
        busy_error_check();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
